//--- include/ring_reader_settings.svh
`ifndef RING_READER_SETTINGS_SVH
`define RING_READER_SETTINGS_SVH

// ==========================================================================
// Sizes of the host-to-device ring reader
// ==========================================================================

// Width of a ring index, so the ring holds 2**RING_IDX_BITS lines
// The ring size must stay a power of two because indices wrap naturally
`define RING_IDX_BITS 8

// Number of reorder slots, which bounds the reads in flight at once
`define SB_ENTRIES 8

// Width of a reorder slot tag, matching SB_ENTRIES
`define SB_IDX_BITS 3

// Width of one cache line of payload
`define LINE_BITS 64

// Width of a host line address, counted in lines and not in bytes
`define ADDR_BITS 32

`endif

//--- design/ring_reader_pkg.sv
`include "ring_reader_settings.svh"

package ring_reader_pkg;

    // ======================================================================
    // Shared word types
    // ======================================================================

    // Index of a line slot in the host ring buffer
    typedef logic [`RING_IDX_BITS-1:0] ring_idx_t;

    // Host address of one line
    typedef logic [`ADDR_BITS-1:0] line_addr_t;

    // Payload of one line
    typedef logic [`LINE_BITS-1:0] line_t;

    // Tag that names one reorder slot, carried with a read and its response
    typedef logic [`SB_IDX_BITS-1:0] sb_tag_t;

    // ======================================================================
    // Reorder slot state
    // ======================================================================

    // A slot is free, waiting on a response, or holding a returned line
    typedef enum logic [1:0] {
        SLOT_FREE = 2'd0,
        SLOT_WAIT = 2'd1,
        SLOT_FULL = 2'd2
    } slot_state_t;

endpackage

//--- design/ring_read_requester.sv
`timescale 1ns/1ns

module ring_read_requester
    import ring_reader_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Base of the ring in host memory, held stable while running
    input  line_addr_t buffer_base,

    // One past the newest line that the host has written
    input  ring_idx_t  newest_line_idx,

    // The scoreboard has a slot ready for the next read
    input  logic       slot_free,

    // Arbiter grant for the current request
    input  logic       read_grant,

    // One line left the scoreboard toward the client
    input  logic       line_consumed,

    output logic       read_req,
    output line_addr_t read_addr,
    output ring_idx_t  oldest_line_idx
);

    // ======================================================================
    // Next line to request
    // ======================================================================

    // Ring index of the next line that has not yet been requested
    ring_idx_t next_idx;

    // The host only grants while read_req is high, so a grant always means
    // there was an unread line and a free slot
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_idx <= '0;
        end
        else if (read_grant)
        begin
            // The ring size is a power of two, so the index wraps by itself
            next_idx <= next_idx + 1'b1;
        end
    end

    // Request whenever unread lines exist and a reorder slot is available
    // This is combinational so a newest index update is seen in its cycle
    assign read_req = (next_idx != newest_line_idx) && slot_free;

    // The address is formed by addition instead of by replacing low bits
    // That way the ring does not have to be aligned to its own size
    assign read_addr = buffer_base + line_addr_t'(next_idx);

    // ======================================================================
    // Oldest consumed line
    // ======================================================================

    // Counting lines as they leave the scoreboard in ring order is simpler
    // than tracking responses that land out of order
    // The host may overwrite every slot below this index
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            oldest_line_idx <= '0;
        end
        else if (line_consumed)
        begin
            oldest_line_idx <= oldest_line_idx + 1'b1;
        end
    end

endmodule

//--- design/reorder_scoreboard.sv
`timescale 1ns/1ns
`include "ring_reader_settings.svh"

module reorder_scoreboard
    import ring_reader_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    // Allocation side, used when a read is granted
    input  logic    alloc_en,
    output logic    slot_free,
    output sb_tag_t alloc_tag,

    // Fill side, used when a tagged response returns
    input  logic    fill_en,
    input  sb_tag_t fill_tag,
    input  line_t   fill_data,

    // Drain side, which hands lines out in allocation order
    input  logic    drain_en,
    output logic    head_full,
    output line_t   head_data
);

    // ======================================================================
    // Slot storage
    // ======================================================================

    // State of each slot, cleared to free on reset
    slot_state_t slot_state [`SB_ENTRIES];

    // Line payload of each slot
    // Only a slot marked full is ever read, so the contents start undefined
    line_t slot_data [`SB_ENTRIES];

    // Next slot to hand out with a read request
    sb_tag_t alloc_ptr;

    // Oldest allocated slot, the next one to leave in ring order
    sb_tag_t head_ptr;

    // ======================================================================
    // Status toward the requester and the output buffer
    // ======================================================================

    // Slots are handed out strictly in order, so only the slot under the
    // allocation pointer matters
    assign slot_free = (slot_state[alloc_ptr] == SLOT_FREE);
    assign alloc_tag = alloc_ptr;

    // The head can leave once its response has arrived
    assign head_full = (slot_state[head_ptr] == SLOT_FULL);
    assign head_data = slot_data[head_ptr];

    // ======================================================================
    // State updates
    // ======================================================================

    // Allocation, fill and drain always touch different slots
    // Allocation needs a free slot, a fill targets a waiting slot and the
    // drain takes a full one, so the three updates never collide
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            alloc_ptr <= '0;
            head_ptr  <= '0;
            for (int i = 0; i < `SB_ENTRIES; i++)
            begin
                slot_state[i] <= SLOT_FREE;
            end
        end
        else
        begin
            // A granted read reserves the slot until its response lands
            if (alloc_en)
            begin
                slot_state[alloc_ptr] <= SLOT_WAIT;
                alloc_ptr             <= alloc_ptr + 1'b1;
            end

            // Responses may land in any order
            if (fill_en)
            begin
                slot_state[fill_tag] <= SLOT_FULL;
            end

            // Draining releases the head and moves on to the next slot
            if (drain_en)
            begin
                slot_state[head_ptr] <= SLOT_FREE;
                head_ptr             <= head_ptr + 1'b1;
            end
        end
    end

    // Response payload capture
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            slot_data[fill_tag] <= fill_data;
        end
    end

endmodule

//--- design/line_out_fifo.sv
`timescale 1ns/1ns

module line_out_fifo
    import ring_reader_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Write side, fed by the scoreboard drain
    input  logic  enq_en,
    input  line_t enq_data,
    output logic  not_full,

    // Read side, presented to the client
    output line_t first,
    input  logic  deq_en,
    output logic  not_empty
);

    // Two entries are enough to pop every cycle while registering the path
    line_t      entry_data [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    // A pop only counts when a line is actually presented
    logic       deq_fire;

    assign deq_fire  = deq_en && not_empty;
    assign not_full  = (count != 2'd2);
    assign not_empty = (count != 2'd0);
    assign first     = entry_data[rd_ptr];

    // Pointers and occupancy, with enqueue and dequeue allowed together
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (deq_fire)
            begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + {1'b0, enq_en} - {1'b0, deq_fire};
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            entry_data[wr_ptr] <= enq_data;
        end
    end

endmodule

//--- design/ring_reader_top.sv
`timescale 1ns/1ns

module ring_reader_top
    import ring_reader_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Ring description published by the host
    input  line_addr_t buffer_base,
    input  ring_idx_t  newest_line_idx,

    // Read request channel toward host memory
    output logic       read_req,
    output line_addr_t read_addr,
    output sb_tag_t    read_tag,
    input  logic       read_grant,

    // Tagged read responses, possibly out of order
    input  logic       rsp_valid,
    input  sb_tag_t    rsp_tag,
    input  line_t      rsp_data,

    // In-order line stream toward the client
    output line_t      rx_data,
    output logic       rx_rdy,
    input  logic       rx_enable,

    // Lines the host may now overwrite
    output ring_idx_t  oldest_line_idx
);

    // ======================================================================
    // Internal connections
    // ======================================================================

    logic  slot_free;
    logic  head_full;
    line_t head_data;
    logic  fifo_not_full;

    // A line moves from the scoreboard head into the output buffer when it
    // has arrived and there is room, and that same move counts as consumed
    logic  drain;

    assign drain = head_full && fifo_not_full;

    // Request side with the ring pointers
    ring_read_requester i_requester (
        .clk             (clk),
        .reset           (reset),
        .buffer_base     (buffer_base),
        .newest_line_idx (newest_line_idx),
        .slot_free       (slot_free),
        .read_grant      (read_grant),
        .line_consumed   (drain),
        .read_req        (read_req),
        .read_addr       (read_addr),
        .oldest_line_idx (oldest_line_idx)
    );

    // Puts out-of-order responses back into ring order
    reorder_scoreboard i_scoreboard (
        .clk       (clk),
        .reset     (reset),
        .alloc_en  (read_grant),
        .slot_free (slot_free),
        .alloc_tag (read_tag),
        .fill_en   (rsp_valid),
        .fill_tag  (rsp_tag),
        .fill_data (rsp_data),
        .drain_en  (drain),
        .head_full (head_full),
        .head_data (head_data)
    );

    // Registered output stage toward the client
    line_out_fifo i_out_fifo (
        .clk       (clk),
        .reset     (reset),
        .enq_en    (drain),
        .enq_data  (head_data),
        .not_full  (fifo_not_full),
        .first     (rx_data),
        .deq_en    (rx_enable),
        .not_empty (rx_rdy)
    );

endmodule

//--- tests/host_memory_model.sv
`timescale 1ns/1ns
`include "ring_reader_settings.svh"

module host_memory_model
    import ring_reader_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    // Lets the testbench hold back every response
    input  logic       respond_en,

    // Read request channel from the DUT
    input  logic       read_req,
    input  line_addr_t read_addr,
    input  sb_tag_t    read_tag,
    output logic       read_grant,

    // Tagged responses back to the DUT
    output logic       rsp_valid,
    output sb_tag_t    rsp_tag,
    output line_t      rsp_data
);

    // Address and remaining delay of the read that holds each tag
    line_addr_t tag_addr [`SB_ENTRIES];
    int         tag_delay [`SB_ENTRIES];
    logic       tag_busy [`SB_ENTRIES];

    // Host memory content: the address in the low half, its inverse above
    function automatic line_t memory_word(line_addr_t addr);
        return {~addr, addr};
    endfunction

    initial
    begin
        read_grant = 1'b0;
        rsp_valid  = 1'b0;
        rsp_tag    = '0;
        rsp_data   = '0;
        for (int t = 0; t < `SB_ENTRIES; t++)
        begin
            tag_busy[t]  = 1'b0;
            tag_delay[t] = 0;
        end
    end

    // ======================================================================
    // Grants and responses, all driven on the falling edge
    // ======================================================================

    always @(negedge clk)
    begin : host_step
        logic sent;
        sent       = 1'b0;
        read_grant = 1'b0;
        rsp_valid  = 1'b0;
        if (!reset)
        begin
            for (int t = 0; t < `SB_ENTRIES; t++)
            begin
                if (tag_busy[t] && tag_delay[t] > 0)
                begin
                    tag_delay[t]--;
                end
            end
            // At most one response per cycle, the lowest ready tag first
            for (int t = 0; t < `SB_ENTRIES; t++)
            begin
                if (respond_en && !sent && tag_busy[t] && tag_delay[t] == 0)
                begin
                    rsp_valid   = 1'b1;
                    rsp_tag     = sb_tag_t'(t);
                    rsp_data    = memory_word(tag_addr[t]);
                    tag_busy[t] = 1'b0;
                    sent        = 1'b1;
                end
            end
            // Roughly one request in three waits a cycle before its grant
            if (read_req && ($urandom % 3) != 0)
            begin
                read_grant          = 1'b1;
                tag_addr[read_tag]  = read_addr;
                tag_delay[read_tag] = 1 + int'($urandom % 20);
                tag_busy[read_tag]  = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_ring_reader_top.sv
`timescale 1ns/1ns

module tb_ring_reader_top
    import ring_reader_pkg::*;
;

    // About 300 lines at a few cycles each, so this bound is far above need
    localparam int TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       reset;
    line_addr_t buffer_base;
    ring_idx_t  newest_line_idx;
    logic       read_req;
    line_addr_t read_addr;
    sb_tag_t    read_tag;
    logic       read_grant;
    logic       rsp_valid;
    sb_tag_t    rsp_tag;
    line_t      rsp_data;
    line_t      rx_data;
    logic       rx_rdy;
    logic       rx_enable;
    ring_idx_t  oldest_line_idx;
    logic       respond_en;
    int         grant_count;
    int         pop_count;
    int         cycle_count;

    ring_reader_top i_dut (.*);

    host_memory_model i_host (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // Compare tasks, one per result type
    // ======================================================================

    task automatic compare_line(line_t got, line_t exp, string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Line data mismatch");
        end
    endtask

    task automatic compare_idx(ring_idx_t got, ring_idx_t exp, string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Ring index mismatch");
        end
    endtask

    task automatic compare_addr(line_addr_t got, line_addr_t exp, string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Read address mismatch");
        end
    endtask

    task automatic compare_tag(sb_tag_t got, sb_tag_t exp, string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Read tag mismatch");
        end
    endtask

    task automatic compare_bit(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s is %b, expected %b", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Control bit mismatch");
        end
    endtask

    // Expected payload of ring slot idx, from the host memory rule
    function automatic line_t expected_line(ring_idx_t idx);
        line_addr_t addr;
        addr = buffer_base + line_addr_t'(idx);
        return {~addr, addr};
    endfunction

    // ======================================================================
    // Monitors, sampled on the rising edge
    // ======================================================================

    // Every grant must address the next ring slot in order
    // Tags are handed out in order too, wrapping over the reorder slots
    always @(posedge clk)
    begin
        if (!reset && read_grant)
        begin
            compare_addr(read_addr, buffer_base + line_addr_t'(ring_idx_t'(grant_count)),
                         "read_addr");
            compare_tag(read_tag, sb_tag_t'(grant_count), "read_tag");
            grant_count++;
        end
    end

    // Every pop must return the next ring line in order
    always @(posedge clk)
    begin
        if (!reset && rx_rdy && rx_enable)
        begin
            compare_line(rx_data, expected_line(ring_idx_t'(pop_count)), "rx_data");
            pop_count++;
        end
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the DUT stopped making progress before the tests ended");
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic wait_pops(int n);
        while (pop_count < n)
            @(negedge clk);
    endtask

    task automatic wait_grants(int n);
        while (grant_count < n)
            @(negedge clk);
    endtask

    // ======================================================================
    // Directed tests
    // ======================================================================

    task automatic check_reset_state();
        compare_bit(read_req, 1'b0, "read_req after reset");
        compare_bit(rx_rdy, 1'b0, "rx_rdy after reset");
        compare_idx(oldest_line_idx, '0, "oldest_line_idx after reset");
    endtask

    task automatic stream_in_order();
        rx_enable       = 1'b1;
        newest_line_idx = ring_idx_t'(40);
        wait_pops(40);
    endtask

    // Drain up to slot 250, then publish 20 more so the index wraps
    task automatic wrap_addresses();
        newest_line_idx = ring_idx_t'(250);
        wait_pops(250);
        newest_line_idx = ring_idx_t'(270);
        wait_pops(270);
        repeat (10)
        begin
            @(negedge clk);
            compare_bit(read_req, 1'b0, "read_req with ring empty");
        end
    endtask

    task automatic fill_scoreboard();
        respond_en      = 1'b0;
        newest_line_idx = ring_idx_t'(282);
        wait_grants(270 + 8);
        repeat (30)
        begin
            @(negedge clk);
            compare_bit(read_req, 1'b0, "read_req with scoreboard full");
        end
        respond_en = 1'b1;
        wait_pops(282);
    endtask

    // Eight slots plus two FIFO entries fill up before requests stop
    task automatic stall_output();
        rx_enable       = 1'b0;
        newest_line_idx = ring_idx_t'(302);
        wait_grants(282 + 10);
        repeat (40)
            @(negedge clk);
        compare_idx(oldest_line_idx, ring_idx_t'(pop_count + 2), "oldest_line_idx stalled");
        compare_bit(read_req, 1'b0, "read_req while stalled");
        rx_enable = 1'b1;
        wait_pops(302);
        @(negedge clk);
        compare_idx(oldest_line_idx, ring_idx_t'(302), "oldest_line_idx at end");
    endtask

    initial
    begin
        void'($urandom(65834));
        reset           = 1'b1;
        buffer_base     = 32'h0000_1000;
        newest_line_idx = '0;
        rx_enable       = 1'b0;
        respond_en      = 1'b1;
        grant_count     = 0;
        pop_count       = 0;
        cycle_count     = 0;
        repeat (16)
            @(negedge clk);
        reset = 1'b0;
        check_reset_state();
        stream_in_order();
        wrap_addresses();
        fill_scoreboard();
        stall_output();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- ring_reader_top.f
+incdir+include
design/ring_reader_pkg.sv
design/ring_read_requester.sv
design/reorder_scoreboard.sv
design/line_out_fifo.sv
design/ring_reader_top.sv
tests/host_memory_model.sv
tests/tb_ring_reader_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f ring_reader_top.f \
    --top-module tb_ring_reader_top -o sim_ring_reader

# A failing run still leaves its log behind for the search below
./obj_dir/sim_ring_reader | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
